/* compile.f */
design/gpio_pkg.sv
design/axil_gpio_frontend.sv
design/gpio_bank.sv
design/gpio_read_collect.sv
design/gpio_top.sv
dv/tb_clock_gen.sv
dv/gpio_tb.sv

/* Makefile */
# Verilator flow for the GPIO testbench
# Any variable can be overridden, e.g. make TOP=gpio_tb LOG=run.log

VERILATOR  ?= verilator
TOP        ?= gpio_tb
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= ALL TESTS PASSED
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The log decides pass or fail, the pipe status does not
run: build
	$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/gpio_tb.sv */
`default_nettype none

module gpio_tb
  import gpio_pkg::*;
();

  localparam int DW        = 32;
  localparam int NUM_BANKS = 4;
  localparam int SW        = DW / 8;
  localparam int BYTE_W    = $clog2(SW);
  localparam int BANK_W    = $clog2(NUM_BANKS);
  localparam int AW        = BANK_W + REG_IDX_W + BYTE_W;
  localparam int CW        = NUM_BANKS * DW;
  // Transactions issued by the sequence below
  localparam int N_TXN     = 144;
  localparam int WD_CYCLES = N_TXN * 200;

  typedef logic [CW-1:0] cval_t;

  wire              bus;
  wire              rst_n;
  logic [AW-1:0]    awaddr;
  logic             awvalid;
  wire              awready;
  logic [DW-1:0]    wdata;
  logic [SW-1:0]    wstrb;
  logic             wvalid;
  wire              wready;
  wire  [1:0]       bresp;
  wire              bvalid;
  logic             bready;
  logic [AW-1:0]    araddr;
  logic             arvalid;
  wire              arready;
  wire  [DW-1:0]    rdata;
  wire  [1:0]       rresp;
  wire              rvalid;
  logic             rready;
  wire  [CW-1:0]    gpio_out;
  wire  [CW-1:0]    gpio_oe;
  logic [CW-1:0]    gpio_in;
  wire              irq;

  // Shadow model of the bank registers
  logic [DW-1:0]    m_out [NUM_BANKS];
  logic [DW-1:0]    m_oe  [NUM_BANKS];
  logic             m_irq [NUM_BANKS];

  // Pending compares filled by the bus tasks
  string            q_name [$];
  cval_t            q_got  [$];
  cval_t            q_exp  [$];
  event             rsp_ev;
  integer           seed;
  int               n_resp;

  tb_clock_gen #(
    .PERIOD     (4),
    .RST_CYCLES (5)
  ) i_clk_gen (
    .bus   (bus),
    .rst_n (rst_n)
  );

  gpio_top #(
    .DW        (DW),
    .NUM_BANKS (NUM_BANKS)
  ) i_dut (
    .bus      (bus),
    .rst_n    (rst_n),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe),
    .gpio_in  (gpio_in),
    .irq      (irq)
  );

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  // Bank index over register index over a zero byte offset
  function automatic logic [AW-1:0] make_addr(input int bank, input gpio_reg_e r);
    return {BANK_W'(bank), r, BYTE_W'(0)};
  endfunction

  function automatic gpio_reg_e reg_of(input int r);
    return gpio_reg_e'(r[REG_IDX_W-1:0]);
  endfunction

  // Mask built from the strobes with one byte per bit
  function automatic logic [DW-1:0] apply_strb(
    input logic [DW-1:0] old_w,
    input logic [DW-1:0] new_w,
    input logic [SW-1:0] strb
  );
    logic [DW-1:0] mask;
    for (int i = 0; i < SW; i++) begin
      mask[i*8 +: 8] = {8{strb[i]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic void model_write(
    input int            bank,
    input gpio_reg_e     r,
    input logic [DW-1:0] data,
    input logic [SW-1:0] strb
  );
    case (r)
      REG_OUT: m_out[bank] = apply_strb(m_out[bank], data, strb);
      REG_OE:  m_oe[bank]  = apply_strb(m_oe[bank], data, strb);
      // Level bit ignores the strobes
      REG_IRQ: m_irq[bank] = data[0];
      default: ;
    endcase
  endfunction

  // Expected pin vector of gpio_oe for REG_OE and of gpio_out otherwise
  function automatic cval_t model_pins(input gpio_reg_e r);
    cval_t v;
    for (int b = 0; b < NUM_BANKS; b++) begin
      v[b*DW +: DW] = (r == REG_OE) ? m_oe[b] : m_out[b];
    end
    return v;
  endfunction

  function automatic logic model_irq();
    logic any;
    any = 1'b0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      any = any | m_irq[b];
    end
    return any;
  endfunction

  // Response code in the top two bits above the read word
  function automatic logic [DW+1:0] exp_read(input int bank, input gpio_reg_e r);
    logic [DW-1:0] word;
    case (r)
      REG_OUT: word = m_out[bank];
      REG_OE:  word = m_oe[bank];
      REG_IN:  word = gpio_in[bank*DW +: DW];
      default: word = {{(DW-1){1'b0}}, m_irq[bank]};
    endcase
    return {RESP_OKAY, word};
  endfunction

  function automatic axi_resp_e exp_wr_resp(input gpio_reg_e r);
    return (r == REG_IN) ? RESP_SLVERR : RESP_OKAY;
  endfunction

  // --------------------------------------------------------------------------
  // Compare
  // --------------------------------------------------------------------------

  function automatic void queue_check(input string name, input cval_t got, input cval_t want);
    q_name.push_back(name);
    q_got.push_back(got);
    q_exp.push_back(want);
  endfunction

  task automatic check_val(input string name, input cval_t got, input cval_t want);
    if (got !== want) begin
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, want);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  // Drains the queue whenever a bus task posts results
  initial begin : compare_proc
    forever begin
      @(rsp_ev);
      while (q_name.size() != 0) begin
        check_val(q_name.pop_front(), q_got.pop_front(), q_exp.pop_front());
      end
    end
  end

  // --------------------------------------------------------------------------
  // Bus tasks
  // --------------------------------------------------------------------------

  // Entered and left one unit after a rising edge
  task automatic axi_write(
    input int            bank,
    input gpio_reg_e     r,
    input logic [DW-1:0] data,
    input logic [SW-1:0] strb
  );
    int    hold;
    cval_t got_resp;
    string tag;
    hold = $random(seed) & 3;
    tag  = $sformatf("bank %0d %s", bank, r.name());
    awaddr  = make_addr(bank, r);
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // Ready visible now means the next edge completes the transfer
    while (!(awready && wready)) begin
      @(posedge bus);
      #1;
    end
    @(posedge bus);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    // Ready pulses end on the transfer edge
    queue_check({"awready after ", tag}, cval_t'(awready), cval_t'(0));
    queue_check({"wready after ", tag}, cval_t'(wready), cval_t'(0));
    while (!bvalid) begin
      @(posedge bus);
      #1;
    end
    repeat (hold) begin
      @(posedge bus);
      #1;
    end
    queue_check({"bvalid held ", tag}, cval_t'(bvalid), cval_t'(1));
    got_resp = cval_t'(bresp);
    bready = 1'b1;
    @(posedge bus);
    #1;
    bready = 1'b0;
    n_resp++;
    model_write(bank, r, data, strb);
    queue_check({"bresp ", tag}, got_resp, cval_t'(exp_wr_resp(r)));
    queue_check({"bvalid after ", tag}, cval_t'(bvalid), cval_t'(0));
    queue_check({"gpio_out after ", tag}, cval_t'(gpio_out), model_pins(REG_OUT));
    queue_check({"gpio_oe after ", tag}, cval_t'(gpio_oe), model_pins(REG_OE));
    queue_check({"irq after ", tag}, cval_t'(irq), cval_t'(model_irq()));
    -> rsp_ev;
  endtask

  task automatic axi_read(input int bank, input gpio_reg_e r);
    logic [DW+1:0] want;
    int            hold;
    cval_t         got_data;
    cval_t         got_resp;
    string         tag;
    want = exp_read(bank, r);
    hold = $random(seed) & 3;
    tag  = $sformatf("bank %0d %s", bank, r.name());
    araddr  = make_addr(bank, r);
    arvalid = 1'b1;
    while (!arready) begin
      @(posedge bus);
      #1;
    end
    @(posedge bus);
    #1;
    arvalid = 1'b0;
    queue_check({"arready after ", tag}, cval_t'(arready), cval_t'(0));
    while (!rvalid) begin
      @(posedge bus);
      #1;
    end
    repeat (hold) begin
      @(posedge bus);
      #1;
    end
    queue_check({"rvalid held ", tag}, cval_t'(rvalid), cval_t'(1));
    got_data = cval_t'(rdata);
    got_resp = cval_t'(rresp);
    rready = 1'b1;
    @(posedge bus);
    #1;
    rready = 1'b0;
    n_resp++;
    queue_check({"rdata ", tag}, got_data, cval_t'(want[DW-1:0]));
    queue_check({"rresp ", tag}, got_resp, cval_t'(want[DW+1:DW]));
    queue_check({"rvalid after ", tag}, cval_t'(rvalid), cval_t'(0));
    -> rsp_ev;
  endtask

  // --------------------------------------------------------------------------
  // Watchdog
  // --------------------------------------------------------------------------

  initial begin : watchdog
    repeat (WD_CYCLES) @(posedge bus);
    $display("Timeout after %0d cycles, the test sequence did not finish", WD_CYCLES);
    $display("SOME TESTS FAILED");
    $fatal(1);
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin : main_seq
    logic [DW-1:0] d;
    logic [SW-1:0] s;
    gpio_reg_e     wr_r;
    gpio_reg_e     rd_r;
    int            rb;
    int            rb2;
    seed    = 73;
    n_resp  = 0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    gpio_in = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      m_out[b] = '0;
      m_oe[b]  = '0;
      m_irq[b] = 1'b0;
    end
    @(posedge rst_n);
    @(posedge bus);
    #1;

    // Reset state of the pins, the handshakes and every register
    queue_check("gpio_out at reset", cval_t'(gpio_out), cval_t'(0));
    queue_check("gpio_oe at reset", cval_t'(gpio_oe), cval_t'(0));
    queue_check("irq at reset", cval_t'(irq), cval_t'(0));
    queue_check("bvalid at reset", cval_t'(bvalid), cval_t'(0));
    queue_check("rvalid at reset", cval_t'(rvalid), cval_t'(0));
    queue_check("awready at reset", cval_t'(awready), cval_t'(0));
    queue_check("wready at reset", cval_t'(wready), cval_t'(0));
    queue_check("arready at reset", cval_t'(arready), cval_t'(0));
    -> rsp_ev;
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int r = 0; r < 4; r++) begin
        axi_read(b, reg_of(r));
      end
    end

    // Byte-strobed writes with readback
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int r = 0; r < 2; r++) begin
        repeat (4) begin
          d = DW'($random(seed));
          s = SW'($random(seed));
          axi_write(b, reg_of(r), d, s);
          axi_read(b, reg_of(r));
        end
      end
    end

    // Input readback after the synchronizer has settled
    repeat (2) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        gpio_in[b*DW +: DW] = DW'($random(seed));
      end
      repeat (3) begin
        @(posedge bus);
        #1;
      end
      for (int b = 0; b < NUM_BANKS; b++) begin
        axi_read(b, REG_IN);
      end
    end

    // Set every irq bit in turn and clear them again with random upper bits
    for (int b = 0; b < NUM_BANKS; b++) begin
      d = DW'($random(seed)) | DW'(1);
      axi_write(b, REG_IRQ, d, SW'($random(seed)));
      axi_read(b, REG_IRQ);
    end
    for (int b = 0; b < NUM_BANKS; b++) begin
      d = DW'($random(seed)) & ~DW'(1);
      axi_write(b, REG_IRQ, d, SW'($random(seed)));
      axi_read(b, REG_IRQ);
    end

    // Writes to the input register must bounce
    for (int b = 0; b < NUM_BANKS; b++) begin
      axi_write(b, REG_IN, DW'($random(seed)), '1);
      axi_read(b, REG_OUT);
    end

    // Write and read in parallel on different banks
    repeat (16) begin
      rb   = $random(seed) & (NUM_BANKS - 1);
      rb2  = rb ^ (1 + ($random(seed) & 1));
      wr_r = reg_of($random(seed));
      rd_r = reg_of($random(seed));
      d    = DW'($random(seed));
      s    = SW'($random(seed));
      fork
        axi_write(rb, wr_r, d, s);
        axi_read(rb2, rd_r);
      join
    end

    // Let the compare process drain
    @(posedge bus);
    #1;
    if (n_resp == N_TXN && q_name.size() == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("Expected %0d responses but counted %0d", N_TXN, n_resp);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 5
) (
  output logic bus,
  output logic rst_n
);

  // Free-running clock
  initial begin
    bus = 1'b0;
    forever #(PERIOD / 2) bus = ~bus;
  end

  // Release one unit after an edge, clear of the flops sampling it
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge bus);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* design/gpio_top.sv */
`default_nettype none

module gpio_top
  import gpio_pkg::*;
#(
  parameter int unsigned  DW        = 32,
  parameter int unsigned  NUM_BANKS = 4,
  localparam int unsigned BYTE_W    = $clog2(DW / 8),
  localparam int unsigned BANK_W    = $clog2(NUM_BANKS),
  localparam int unsigned AW        = BANK_W + REG_IDX_W + BYTE_W
) (
  input  wire                    bus,
  input  wire                    rst_n,
  // AXI4-Lite slave
  input  wire [AW-1:0]           awaddr,
  input  wire                    awvalid,
  output wire                    awready,
  input  wire [DW-1:0]           wdata,
  input  wire [DW/8-1:0]         wstrb,
  input  wire                    wvalid,
  output wire                    wready,
  output wire [1:0]              bresp,
  output wire                    bvalid,
  input  wire                    bready,
  input  wire [AW-1:0]           araddr,
  input  wire                    arvalid,
  output wire                    arready,
  output wire [DW-1:0]           rdata,
  output wire [1:0]              rresp,
  output wire                    rvalid,
  input  wire                    rready,
  // GPIO pins, bank k in slice k
  output wire [NUM_BANKS*DW-1:0] gpio_out,
  output wire [NUM_BANKS*DW-1:0] gpio_oe,
  input  wire [NUM_BANKS*DW-1:0] gpio_in,
  output wire                    irq
);

  // Write broadcast
  wire [NUM_BANKS-1:0]    bank_wr_en;
  wire gpio_reg_e         wr_reg;
  wire [DW-1:0]           wr_data;
  wire [DW/8-1:0]         wr_strb;
  // Read request
  wire                    rd_en;
  wire [BANK_W-1:0]       rd_bank;
  wire gpio_reg_e         rd_reg;
  // Bank words not already on the pins
  wire [NUM_BANKS*DW-1:0] bank_in;
  wire [NUM_BANKS-1:0]    bank_irq;

  axil_gpio_frontend #(
    .DW        (DW),
    .NUM_BANKS (NUM_BANKS)
  ) i_frontend (
    .bus        (bus),
    .rst_n      (rst_n),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .bank_wr_en (bank_wr_en),
    .wr_reg     (wr_reg),
    .wr_data    (wr_data),
    .wr_strb    (wr_strb),
    .rd_en      (rd_en),
    .rd_bank    (rd_bank),
    .rd_reg     (rd_reg)
  );

  // One bank per slice, output registers drive the pins directly
  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
    gpio_bank #(
      .DW (DW)
    ) i_bank (
      .bus     (bus),
      .rst_n   (rst_n),
      .wr_en   (bank_wr_en[k]),
      .wr_reg  (wr_reg),
      .wr_data (wr_data),
      .wr_strb (wr_strb),
      .pin_in  (gpio_in[k*DW +: DW]),
      .pin_out (gpio_out[k*DW +: DW]),
      .pin_oe  (gpio_oe[k*DW +: DW]),
      .in_sync (bank_in[k*DW +: DW]),
      .irq_bit (bank_irq[k])
    );
  end

  gpio_read_collect #(
    .DW        (DW),
    .NUM_BANKS (NUM_BANKS)
  ) i_read_collect (
    .bus      (bus),
    .rst_n    (rst_n),
    .rd_en    (rd_en),
    .rd_bank  (rd_bank),
    .rd_reg   (rd_reg),
    .bank_out (gpio_out),
    .bank_oe  (gpio_oe),
    .bank_in  (bank_in),
    .bank_irq (bank_irq),
    .rdata    (rdata),
    .irq      (irq)
  );

endmodule

`default_nettype wire

/* design/gpio_read_collect.sv */
`default_nettype none

module gpio_read_collect
  import gpio_pkg::*;
#(
  parameter int unsigned  DW        = 32,
  parameter int unsigned  NUM_BANKS = 4,
  localparam int unsigned BANK_W    = $clog2(NUM_BANKS)
) (
  input  wire                    bus,
  input  wire                    rst_n,
  // Read request from the front end
  input  wire                    rd_en,
  input  wire [BANK_W-1:0]       rd_bank,
  input  wire gpio_reg_e         rd_reg,
  // Bank words, bank k in slice k
  input  wire [NUM_BANKS*DW-1:0] bank_out,
  input  wire [NUM_BANKS*DW-1:0] bank_oe,
  input  wire [NUM_BANKS*DW-1:0] bank_in,
  input  wire [NUM_BANKS-1:0]    bank_irq,
  output logic [DW-1:0]          rdata,
  output logic                   irq
);

  logic [DW-1:0] sel_word;

  // --------------------------------------------------------------------------
  // Word select
  // --------------------------------------------------------------------------

  always_comb begin
    case (rd_reg)
      REG_OUT: sel_word = bank_out[rd_bank*DW +: DW];
      REG_OE:  sel_word = bank_oe[rd_bank*DW +: DW];
      REG_IN:  sel_word = bank_in[rd_bank*DW +: DW];
      // Single bit, zero-extended
      REG_IRQ: sel_word = {{(DW-1){1'b0}}, bank_irq[rd_bank]};
      default: sel_word = '0;
    endcase
  end

  // Loaded on the edge that raises rvalid, held until the next read
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (rd_en) begin
      rdata <= sel_word;
    end
  end

  // Any bank with its level set
  assign irq = |bank_irq;

  // Bank index comes from a register without reset in the front end
  a_rd_known: assert property (@(posedge bus) disable iff (!rst_n)
    rd_en |-> !$isunknown({rd_bank, rd_reg}));

endmodule

`default_nettype wire

/* design/gpio_bank.sv */
`default_nettype none

module gpio_bank
  import gpio_pkg::*;
#(
  parameter int unsigned DW = 32
) (
  input  wire            bus,
  input  wire            rst_n,
  // Write broadcast, this bank's enable only
  input  wire            wr_en,
  input  wire gpio_reg_e wr_reg,
  input  wire [DW-1:0]   wr_data,
  input  wire [DW/8-1:0] wr_strb,
  // Pins
  input  wire [DW-1:0]   pin_in,
  output logic [DW-1:0]  pin_out,
  output logic [DW-1:0]  pin_oe,
  // Words seen by the read collector
  output logic [DW-1:0]  in_sync,
  output logic           irq_bit
);

  // First synchronizer stage, may go metastable
  logic [DW-1:0] in_meta;

  logic [DW-1:0] out_next;
  logic [DW-1:0] oe_next;

  // --------------------------------------------------------------------------
  // Byte merge
  // --------------------------------------------------------------------------

  // Enabled bytes from the new word, the rest kept
  function automatic logic [DW-1:0] byte_merge(
    input logic [DW-1:0]   old_word,
    input logic [DW-1:0]   new_word,
    input logic [DW/8-1:0] strb
  );
    logic [DW-1:0] merged;
    merged = old_word;
    for (int i = 0; i < DW / 8; i++) begin
      if (strb[i]) begin
        merged[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return merged;
  endfunction

  assign out_next = byte_merge(pin_out, wr_data, wr_strb);
  assign oe_next  = byte_merge(pin_oe, wr_data, wr_strb);

  // --------------------------------------------------------------------------
  // Software registers
  // --------------------------------------------------------------------------

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      pin_out <= '0;
      pin_oe  <= '0;
      irq_bit <= 1'b0;
    end else if (wr_en) begin
      case (wr_reg)
        REG_OUT: pin_out <= out_next;
        REG_OE:  pin_oe  <= oe_next;
        // Level only, bit 0 of the data
        REG_IRQ: irq_bit <= wr_data[0];
        default: ;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Input synchronizer
  // --------------------------------------------------------------------------

  // Two flops, readable from the second
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= pin_in;
      in_sync <= in_meta;
    end
  end

  // Front end filters writes to the read-only register
  a_no_write_in: assert property (@(posedge bus) disable iff (!rst_n)
    wr_en |-> (wr_reg != REG_IN));

endmodule

`default_nettype wire

/* design/axil_gpio_frontend.sv */
`default_nettype none

module axil_gpio_frontend
  import gpio_pkg::*;
#(
  parameter int unsigned  DW        = 32,
  parameter int unsigned  NUM_BANKS = 4,
  localparam int unsigned BYTE_W    = $clog2(DW / 8),
  localparam int unsigned BANK_W    = $clog2(NUM_BANKS),
  localparam int unsigned AW        = BANK_W + REG_IDX_W + BYTE_W
) (
  input  wire                  bus,
  input  wire                  rst_n,
  // Write address and data channels
  input  wire [AW-1:0]         awaddr,
  input  wire                  awvalid,
  output logic                 awready,
  input  wire [DW-1:0]         wdata,
  input  wire [DW/8-1:0]       wstrb,
  input  wire                  wvalid,
  output logic                 wready,
  // Write response channel
  output axi_resp_e            bresp,
  output logic                 bvalid,
  input  wire                  bready,
  // Read address and data channels
  input  wire [AW-1:0]         araddr,
  input  wire                  arvalid,
  output logic                 arready,
  output axi_resp_e            rresp,
  output logic                 rvalid,
  input  wire                  rready,
  // Write broadcast to the banks
  output logic [NUM_BANKS-1:0] bank_wr_en,
  output gpio_reg_e            wr_reg,
  output logic [DW-1:0]        wr_data,
  output logic [DW/8-1:0]      wr_strb,
  // Read request to the collector
  output logic                 rd_en,
  output logic [BANK_W-1:0]    rd_bank,
  output gpio_reg_e            rd_reg
);

  // Word index of the latched addresses, byte offset dropped
  logic [AW-1:BYTE_W] aw_idx_q;
  logic [AW-1:BYTE_W] ar_idx_q;

  logic               wr_accept;
  logic               wr_xfer;
  logic               ar_accept;
  logic               ar_xfer;
  logic [BANK_W-1:0]  wr_bank;
  gpio_reg_e          wr_reg_dec;
  logic               wr_to_ro;

  // --------------------------------------------------------------------------
  // Write path
  // --------------------------------------------------------------------------

  // Both channels seen, nothing in flight
  assign wr_accept = awvalid & wvalid & ~awready & ~wready & ~bvalid;
  // Address and data complete on the same edge
  assign wr_xfer   = awready & awvalid & wready & wvalid;

  // Ready pulses last exactly one cycle
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
    end else begin
      awready <= wr_accept;
      wready  <= wr_accept;
    end
  end

  always_ff @(posedge bus) begin
    if (wr_accept) begin
      aw_idx_q <= awaddr[AW-1:BYTE_W];
    end
  end

  // Bank index on top, register index below it
  assign wr_bank    = aw_idx_q[AW-1 -: BANK_W];
  assign wr_reg_dec = gpio_reg_e'(aw_idx_q[BYTE_W +: REG_IDX_W]);
  assign wr_to_ro   = (wr_reg_dec == REG_IN);

  // Strobe and response leave together, one cycle after the transfer
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      bank_wr_en <= '0;
      bvalid     <= 1'b0;
      bresp      <= RESP_OKAY;
    end else begin
      bank_wr_en <= '0;
      if (wr_xfer) begin
        // Input register is read only, no bank sees the write
        if (!wr_to_ro) begin
          bank_wr_en[wr_bank] <= 1'b1;
        end
        bvalid <= 1'b1;
        bresp  <= wr_to_ro ? RESP_SLVERR : RESP_OKAY;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Payload of the broadcast, qualified by bank_wr_en
  always_ff @(posedge bus) begin
    if (wr_xfer) begin
      wr_reg  <= wr_reg_dec;
      wr_data <= wdata;
      wr_strb <= wstrb;
    end
  end

  // --------------------------------------------------------------------------
  // Read path
  // --------------------------------------------------------------------------

  // Also blocked during the rd_en cycle, before rvalid is up
  assign ar_accept = arvalid & ~arready & ~rvalid & ~rd_en;
  assign ar_xfer   = arready & arvalid;

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rd_en   <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= ar_accept;
      rd_en   <= ar_xfer;
      // rvalid rises on the edge that loads rdata in the collector
      if (rd_en) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge bus) begin
    if (ar_accept) begin
      ar_idx_q <= araddr[AW-1:BYTE_W];
    end
    if (ar_xfer) begin
      rd_bank <= ar_idx_q[AW-1 -: BANK_W];
      rd_reg  <= gpio_reg_e'(ar_idx_q[BYTE_W +: REG_IDX_W]);
    end
  end

  // Every register is readable
  assign rresp = RESP_OKAY;

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  a_wr_en_onehot: assert property (@(posedge bus) disable iff (!rst_n)
    $onehot0(bank_wr_en));

  a_no_aw_during_b: assert property (@(posedge bus) disable iff (!rst_n)
    !(awready && bvalid));

  a_no_rd_during_r: assert property (@(posedge bus) disable iff (!rst_n)
    !(rd_en && rvalid));

endmodule

`default_nettype wire

/* design/gpio_pkg.sv */
`default_nettype none

package gpio_pkg;

  // --------------------------------------------------------------------------
  // Address fields
  // --------------------------------------------------------------------------

  // Width of the register index field inside one bank
  localparam int unsigned REG_IDX_W = 2;

  // --------------------------------------------------------------------------
  // Register map of one bank
  // --------------------------------------------------------------------------

  typedef enum logic [REG_IDX_W-1:0] {
    REG_OUT = 2'd0,  // output data, byte-strobed
    REG_OE  = 2'd1,  // output enable, byte-strobed
    REG_IN  = 2'd2,  // Synchronized pins, read only
    REG_IRQ = 2'd3   // Software-written interrupt level in bit 0
  } gpio_reg_e;

  // --------------------------------------------------------------------------
  // AXI response codes
  // --------------------------------------------------------------------------

  // Only the two codes this slave can return
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

`default_nettype wire
